// ==== nnTop.f ====
+incdir+.
nnPkg.sv
neuronNode.sv
streamFifo.sv
denseLayer.sv
nnTop.sv
nnTop_tb.sv

// ==== Makefile ====
# Verilator build for the dense layer block
VERILATOR ?= verilator
FILELIST ?= nnTop.f
TOP ?= nnTop_tb
RTL_TOP ?= nnTop
BUILD_DIR ?= obj_dir
JOBS ?= 4
VFLAGS ?= --timing --assert
LINT_FLAGS ?= --lint-only
SIM_ARGS ?=

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(FILELIST) *.sv *.svh
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

# Exit status of the simulation is the pass or fail result
sim: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== nnTop_tb.sv ====
`timescale 1ns/10ps
`include "nnLayer_defs.svh"

module nnTop_tb;
	import nnPkg::*;

	localparam int caseCount = 10;
	localparam int timeoutCycles = 200;
	localparam int capacity = `NN_IN_DEPTH + `NN_OUT_DEPTH + 3; // Both FIFOs plus three stages

	localparam logic signed [7:0] weightTab [nodeCount][inCount] = '{
		'{`NN_W_0_0, `NN_W_0_1, `NN_W_0_2, `NN_W_0_3, `NN_W_0_4,
			`NN_W_0_5, `NN_W_0_6, `NN_W_0_7, `NN_W_0_8, `NN_W_0_9},
		'{`NN_W_1_0, `NN_W_1_1, `NN_W_1_2, `NN_W_1_3, `NN_W_1_4,
			`NN_W_1_5, `NN_W_1_6, `NN_W_1_7, `NN_W_1_8, `NN_W_1_9},
		'{`NN_W_2_0, `NN_W_2_1, `NN_W_2_2, `NN_W_2_3, `NN_W_2_4,
			`NN_W_2_5, `NN_W_2_6, `NN_W_2_7, `NN_W_2_8, `NN_W_2_9},
		'{`NN_W_3_0, `NN_W_3_1, `NN_W_3_2, `NN_W_3_3, `NN_W_3_4,
			`NN_W_3_5, `NN_W_3_6, `NN_W_3_7, `NN_W_3_8, `NN_W_3_9}
	};
	localparam logic signed [15:0] biasTab [nodeCount] = '{`NN_B_0, `NN_B_1, `NN_B_2, `NN_B_3};

	// Activations act[0] first
	localparam int caseActs [caseCount][inCount] = '{
		'{3, -2, 5, 1, 0, 7, -4, 2, 6, -1},
		'{10, 4, -6, 2, 9, -3, 1, 0, -5, 8},
		'{12, 0, 0, 0, 0, 0, 0, 0, 0, 0}, // Node 3 sum 224 with low bits exactly half
		'{13, 0, 0, 0, 0, 0, 0, 0, 0, 0}, // Node 3 sum 226
		'{0, -128, 0, 0, 0, 0, 0, 0, 0, 0}, // Node 0 sum -3968
		'{0, 127, 127, 0, 127, 0, 0, 0, 0, 0}, // Node 0 sum 11811
		'{0, 127, 127, 0, 10, 0, 0, 0, 0, 0}, // Node 0 sum 8184 would round to 128
		'{-7, 15, 20, -9, 11, 3, -2, 5, 0, 4},
		'{1, 1, 1, 1, 1, 1, 1, 1, 1, 1},
		'{-20, 30, -1, 8, 25, -16, 7, -3, 12, 9}
	};

	// Hand-derived node value per case where the node is not -1
	localparam int spotNode [caseCount] = '{-1, -1, 3, 3, 0, 0, 0, -1, -1, -1};
	localparam int spotValue [caseCount] = '{0, 0, 3, 4, 0, 127, 127, 0, 0, 0};

	string caseName [caseCount] = '{
		"mixedA", "mixedB", "halfDown", "roundUp", "negative",
		"saturate", "roundClamp", "mixedC", "mixedD", "mixedE"
	};

	logic clk = 1'b0;
	logic reset;
	sampleT sample;
	logic sampleValid;
	logic sampleReady;
	resultT result;
	logic resultValid;
	logic resultReady;

	resultT expQ [$]; // Scoreboard
	int idxQ [$];
	int sent;

	nnTop UUT (
		.clk(clk),
		.reset(reset),
		.sample(sample),
		.sampleValid(sampleValid),
		.sampleReady(sampleReady),
		.result(result),
		.resultValid(resultValid),
		.resultReady(resultReady)
	);

	always #50 clk = ~clk;

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			failRun($sformatf("ERROR %s: expected %08h, actual %08h", testName, expected, actual));
	endtask

	function automatic sampleT sampleOf(input int idx);
		sampleT s;
		for (int k = 0; k < inCount; k++)
			s.act[k] = activT'(caseActs[idx][k]);
		return s;
	endfunction

	// Reference neuron rule on the header weights
	function automatic resultT modelLayer(input sampleT s);
		resultT r;
		int acc;
		int q;
		for (int n = 0; n < nodeCount; n++)
		begin
			acc = int'(biasTab[n]);
			for (int k = 0; k < inCount; k++)
				acc = acc + int'(s.act[k]) * int'(weightTab[n][k]);
			if (acc < 0)
				r.node[n] = 8'd0;
			else if (acc >= 8192)
				r.node[n] = 8'd127; // Any of bits 21 to 13
			else
			begin
				q = acc / 64;
				if (acc % 64 > 32)
					q++; // Only strictly above half
				r.node[n] = (q > 127) ? 8'd127 : 8'(q);
			end
		end
		return r;
	endfunction

	// Entered and left on a falling edge
	task automatic sendCase(input int idx);
		int waited;
		waited = 0;
		sample = sampleOf(idx);
		sampleValid = 1'b1;
		while (!sampleReady)
		begin
			@(negedge clk);
			waited++;
			if (waited > timeoutCycles)
				failRun("Timeout: the input stream never accepted a sample");
		end
		expQ.push_back(modelLayer(sample));
		idxQ.push_back(idx);
		@(negedge clk); // Transfer on the rising edge in between
		sampleValid = 1'b0;
	endtask

	task automatic sendTable(input int passes);
		for (int p = 0; p < passes; p++)
			for (int i = 0; i < caseCount; i++)
				sendCase(i);
	endtask

	task automatic receiveResults(input int count, input bit randomReady);
		int got;
		int idle;
		int idx;
		resultT expected;
		got = 0;
		idle = 0;
		while (got < count)
		begin
			resultReady = randomReady ? (($urandom % 4) != 0) : 1'b1;
			if (resultValid && resultReady)
			begin
				if (expQ.size() == 0)
					failRun("A result arrived with no sample outstanding");
				expected = expQ.pop_front();
				idx = idxQ.pop_front();
				checkValue($sformatf("%s result", caseName[idx]), expected, result);
				if (spotNode[idx] >= 0)
					checkValue($sformatf("%s node %0d", caseName[idx], spotNode[idx]),
						spotValue[idx], 32'(result.node[spotNode[idx]]));
				got++;
				idle = 0;
			end
			else
			begin
				idle++;
				if (idle > timeoutCycles)
					failRun("Timeout: an expected result never came out");
			end
			@(negedge clk);
		end
		resultReady = 1'b0;
	endtask

	// No extra results once the scoreboard is empty
	task automatic checkDrained();
		resultReady = 1'b1;
		for (int c = 0; c < 10; c++)
		begin
			checkValue("drainedResultValid", 32'd0, 32'(resultValid));
			@(negedge clk);
		end
		resultReady = 1'b0;
		checkValue("drainedSampleReady", 32'd1, 32'(sampleReady));
	endtask

	initial
	begin
		void'($urandom(32'hafd0_1182));
		reset = 1'b1;
		sample = '0;
		sampleValid = 1'b0;
		resultReady = 1'b0;
		sent = 0;
		repeat (5) @(negedge clk);
		reset = 1'b0;

		checkValue("resetResultValid", 32'd0, 32'(resultValid));
		checkValue("resetSampleReady", 32'd1, 32'(sampleReady));

		// Whole table with the output always ready
		fork
			sendTable(1);
			receiveResults(caseCount, 1'b0);
		join

		// Output blocked until the input side refuses
		while (sampleReady)
		begin
			sendCase(sent % caseCount);
			sent++;
			if (sent > 2 * capacity)
				failRun("The input stayed ready while the output was blocked");
		end
		checkValue("fillCapacity", capacity, sent);
		checkValue("fillResultValid", 32'd1, 32'(resultValid));
		receiveResults(sent, 1'b0);

		fork
			sendTable(3);
			receiveResults(3 * caseCount, 1'b1);
		join

		checkDrained();

		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== nnTop.sv ====
`timescale 1ns/10ps
`include "nnLayer_defs.svh"

module nnTop (
	input logic clk,
	input logic reset,
	input nnPkg::sampleT sample,
	input logic sampleValid,
	output logic sampleReady,
	output nnPkg::resultT result,
	output logic resultValid,
	input logic resultReady
);
	import nnPkg::*;

	sampleT headSample;
	logic headValid;
	logic headReady;
	resultT layerResult;
	logic layerValid;
	logic outFifoReady;

	streamFifo #(
		.payloadT(sampleT),
		.DEPTH(`NN_IN_DEPTH)
	) uInFifo (
		.clk(clk),
		.reset(reset),
		.inData(sample),
		.inValid(sampleValid),
		.inReady(sampleReady),
		.outData(headSample),
		.outValid(headValid),
		.outReady(headReady)
	);

	denseLayer uLayer (
		.clk(clk),
		.reset(reset),
		.inSample(headSample),
		.inValid(headValid),
		.inReady(headReady),
		.outResult(layerResult),
		.outValid(layerValid),
		.outFull(!outFifoReady) // Output FIFO full
	);

	streamFifo #(
		.payloadT(resultT),
		.DEPTH(`NN_OUT_DEPTH)
	) uOutFifo (
		.clk(clk),
		.reset(reset),
		.inData(layerResult),
		.inValid(layerValid),
		.inReady(outFifoReady),
		.outData(result),
		.outValid(resultValid),
		.outReady(resultReady)
	);

endmodule

// ==== denseLayer.sv ====
`timescale 1ns/10ps
`include "nnLayer_defs.svh"

module denseLayer (
	input logic clk,
	input logic reset,
	input nnPkg::sampleT inSample,
	input logic inValid,
	output logic inReady,
	output nnPkg::resultT outResult,
	output logic outValid,
	input logic outFull
);
	import nnPkg::*;

	// Leftmost entry is the highest index
	localparam logic [nodeCount-1:0][inCount-1:0][7:0] nodeWeights = '{
		'{`NN_W_3_9, `NN_W_3_8, `NN_W_3_7, `NN_W_3_6, `NN_W_3_5,
			`NN_W_3_4, `NN_W_3_3, `NN_W_3_2, `NN_W_3_1, `NN_W_3_0},
		'{`NN_W_2_9, `NN_W_2_8, `NN_W_2_7, `NN_W_2_6, `NN_W_2_5,
			`NN_W_2_4, `NN_W_2_3, `NN_W_2_2, `NN_W_2_1, `NN_W_2_0},
		'{`NN_W_1_9, `NN_W_1_8, `NN_W_1_7, `NN_W_1_6, `NN_W_1_5,
			`NN_W_1_4, `NN_W_1_3, `NN_W_1_2, `NN_W_1_1, `NN_W_1_0},
		'{`NN_W_0_9, `NN_W_0_8, `NN_W_0_7, `NN_W_0_6, `NN_W_0_5,
			`NN_W_0_4, `NN_W_0_3, `NN_W_0_2, `NN_W_0_1, `NN_W_0_0}
	};
	localparam logic [nodeCount-1:0][15:0] nodeBias = '{`NN_B_3, `NN_B_2, `NN_B_1, `NN_B_0};

	logic enable;
	logic [2:0] validPipe; // One bit per stage

	// Hold everything while a finished result cannot leave
	assign enable = !(validPipe[2] && outFull);
	assign inReady = enable;
	assign outValid = validPipe[2];

	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else if (enable)
			validPipe <= {validPipe[1:0], inValid};
	end

	for (genvar n = 0; n < nodeCount; n++)
	begin : gNode
		neuronNode #(
			.weights(nodeWeights[n]),
			.bias(nodeBias[n])
		) uNode (
			.clk(clk),
			.reset(reset),
			.enable(enable),
			.activations(inSample),
			.node(outResult.node[n])
		);
	end

	assert property (@(posedge clk) disable iff (reset)
		(outFull && !enable) |=> !$rose(outValid))
		else $error("denseLayer result moved while stalled");

endmodule

// ==== streamFifo.sv ====
`timescale 1ns/10ps

module streamFifo #(
	parameter type payloadT = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic reset,
	input payloadT inData,
	input logic inValid,
	output logic inReady,
	output payloadT outData,
	output logic outValid,
	input logic outReady
);

	localparam int ptrWidth = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int cntWidth = $clog2(DEPTH + 1);

	payloadT mem [DEPTH];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [cntWidth-1:0] count;
	logic push;
	logic pop;

	assign inReady = (count != cntWidth'(DEPTH));
	assign outValid = (count != '0);
	assign outData = mem[rdPtr]; // Head shown ahead of the pop

	assign push = inValid && inReady;
	assign pop = outValid && outReady;

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wrPtr] <= inData;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= (wrPtr == ptrWidth'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == ptrWidth'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// Overflow
	assert property (@(posedge clk) disable iff (reset) count <= cntWidth'(DEPTH))
		else $error("streamFifo overflow");

	// An empty FIFO can only grow, never wrap below zero
	assert property (@(posedge clk) disable iff (reset)
		(count == '0) |=> (count <= cntWidth'(1)))
		else $error("streamFifo underflow");

endmodule

// ==== neuronNode.sv ====
`timescale 1ns/10ps

module neuronNode #(
	parameter logic [nnPkg::inCount-1:0][7:0] weights = '0,
	parameter logic [15:0] bias = '0
) (
	input logic clk,
	input logic reset,
	input logic enable,
	input nnPkg::sampleT activations,
	output logic [7:0] node
);
	import nnPkg::*;

	sampleT actReg; // Stage 1
	accT sumReg; // Stage 2
	accT sum;
	logic signed [15:0] prod [inCount];
	logic roundUp;
	logic [7:0] rounded;
	logic [7:0] nodeNext;

	// Multiply-accumulate on the registered sample
	always_comb
	begin
		sum = accT'($signed(bias));
		for (int k = 0; k < inCount; k++)
		begin
			prod[k] = $signed(actReg.act[k]) * $signed(weights[k]);
			sum = sum + accT'(prod[k]);
		end
	end

	// Exact half stays down
	assign roundUp = sumReg[5] && (sumReg[4:0] != 5'd0);
	assign rounded = sumReg[13:6] + {7'd0, roundUp};

	always_comb
	begin
		if (sumReg[22])
			nodeNext = 8'd0; // ReLU
		else if (sumReg[21:13] != 9'd0)
			nodeNext = 8'd127; // Saturate
		else if (rounded[7])
			nodeNext = 8'd127; // 127 rounded up to 128
		else
			nodeNext = rounded;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
			sumReg <= '0;
			node <= 8'd0;
		end
		else if (enable)
		begin
			actReg <= activations;
			sumReg <= sum;
			node <= nodeNext;
		end
	end

	assert property (@(posedge clk) disable iff (reset) node <= 8'd127)
		else $error("neuronNode output above 127");

endmodule

// ==== nnPkg.sv ====
`include "nnLayer_defs.svh"

package nnPkg;

	localparam int inCount = `NN_IN_COUNT;
	localparam int nodeCount = `NN_NODE_COUNT;

	// One signed activation
	typedef logic signed [7:0] activT;

	// Bias plus ten sign-extended 16-bit products
	typedef logic signed [22:0] accT;

	typedef struct packed {
		activT [inCount-1:0] act; // act[0] in the low byte
	} sampleT;

	// ReLU outputs of 0 to 127 each
	typedef struct packed {
		logic [nodeCount-1:0][7:0] node;
	} resultT;

endpackage

// ==== nnLayer_defs.svh ====
`ifndef NN_LAYER_DEFS_SVH
`define NN_LAYER_DEFS_SVH

// Layer shape
`define NN_IN_COUNT 10
`define NN_NODE_COUNT 4

// FIFO depths
`define NN_IN_DEPTH 4
`define NN_OUT_DEPTH 4

// Neuron 0
`define NN_W_0_0 (-8'sd8)
`define NN_W_0_1 8'sd31
`define NN_W_0_2 8'sd31
`define NN_W_0_3 (-8'sd31)
`define NN_W_0_4 8'sd31
`define NN_W_0_5 8'sd12
`define NN_W_0_6 (-8'sd20)
`define NN_W_0_7 (-8'sd1)
`define NN_W_0_8 (-8'sd21)
`define NN_W_0_9 8'sd1
`define NN_B_0 16'sd0

// Neuron 1
`define NN_W_1_0 8'sd5
`define NN_W_1_1 (-8'sd3)
`define NN_W_1_2 8'sd12
`define NN_W_1_3 8'sd7
`define NN_W_1_4 (-8'sd9)
`define NN_W_1_5 8'sd4
`define NN_W_1_6 8'sd2
`define NN_W_1_7 (-8'sd6)
`define NN_W_1_8 8'sd10
`define NN_W_1_9 8'sd1
`define NN_B_1 16'sd64

// Neuron 2
`define NN_W_2_0 (-8'sd12)
`define NN_W_2_1 8'sd9
`define NN_W_2_2 (-8'sd4)
`define NN_W_2_3 8'sd15
`define NN_W_2_4 8'sd3
`define NN_W_2_5 (-8'sd7)
`define NN_W_2_6 8'sd11
`define NN_W_2_7 (-8'sd2)
`define NN_W_2_8 8'sd6
`define NN_W_2_9 (-8'sd5)
`define NN_B_2 (-16'sd128)

// Neuron 3, flat weights
`define NN_W_3_0 8'sd2
`define NN_W_3_1 8'sd2
`define NN_W_3_2 8'sd2
`define NN_W_3_3 8'sd2
`define NN_W_3_4 8'sd2
`define NN_W_3_5 8'sd2
`define NN_W_3_6 8'sd2
`define NN_W_3_7 8'sd2
`define NN_W_3_8 8'sd2
`define NN_W_3_9 8'sd2
`define NN_B_3 16'sd200

`endif
